// File: ctl_top.f
logic/ctl_pkg.sv
logic/cmd_decode.sv
logic/cfg0_reg.sv
logic/read_sequencer.sv
logic/ctl_top.sv
tests/ctl_checker.sv
tests/ctl_top_tb.sv

// File: logic/cfg0_reg.sv
// cfg0 control register with replace, set, clear and toggle writes and its status taps
module cfg0_reg
  import ctl_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              we,
  input  wr_mode_e          mode,
  input  logic [DATA_W-1:0] wdat,
  output logic [DATA_W-1:0] cfg0,
  output logic [WAIT_W-1:0] wait_cnt,
  output logic              run_mode,
  output logic              error,
  output logic [USER_W-1:0] user_out
);

  logic [DATA_W-1:0] cfg0_nxt;

  // new value for each write mode
  always_comb begin
    case (mode)
      WR_REPLACE: cfg0_nxt = wdat;
      WR_SET:     cfg0_nxt = cfg0 | wdat;
      WR_CLEAR:   cfg0_nxt = cfg0 & ~wdat;
      default:    cfg0_nxt = cfg0 ^ wdat;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      cfg0 <= CFG0_INIT;
    end else if (we) begin
      cfg0 <= cfg0_nxt;
    end
  end

  // read wait cycles, low bits
  assign wait_cnt = cfg0[WAIT_W-1:0];

  // pins driven straight from the register
  assign run_mode = cfg0[CFG0_RUN_BIT];
  assign error    = cfg0[CFG0_ERR_BIT];
  assign user_out = cfg0[CFG0_USER_LSB +: USER_W];

endmodule

// File: logic/cmd_decode.sv
// combinational command decode: accepts a command and turns it into array, cfg0 and read strobes
module cmd_decode
  import ctl_pkg::*;
(
  input  logic              ctl_cmd_val,
  input  logic              ra_cmd_val,
  input  cmd_adr_t          cmd_adr,
  input  logic              cmd_we,
  input  logic [3:0]        cmd_sel,
  input  logic [DATA_W-1:0] cmd_dat,
  input  logic              idle,
  output logic              cmd_ready,
  output logic              r0_enb,
  output logic [ROW_W-1:0]  r0_adr,
  output logic              r1_enb,
  output logic [ROW_W-1:0]  r1_adr,
  output logic              w0_enb,
  output logic [ROW_W-1:0]  w0_adr,
  output logic [DATA_W-1:0] w0_dat,
  output logic [DATA_W-1:0] bist_ctl,
  output logic              acfg_wr,
  output logic [DATA_W-1:0] acfg_wdat,
  output logic              cfg0_we,
  output wr_mode_e          cfg0_mode,
  output logic              rd_start,
  output rd_src_e           rd_src
);

  logic ctl_acc;
  logic ra_acc;
  logic sel_bist;
  logic sel_acfg;
  logic sel_cfg0;
  logic port_acc;
  logic port_rd;

  // no new command while a read is outstanding
  assign cmd_ready = idle;
  assign ctl_acc   = ctl_cmd_val & idle;
  assign ra_acc    = ra_cmd_val & idle;

  // selector byte, shared by both command kinds
  assign sel_cfg0 = (cmd_adr.ctl.reg_sel == SEL_CFG0);
  assign sel_bist = (cmd_adr.ctl.reg_sel == SEL_BIST);
  assign sel_acfg = (cmd_adr.ctl.reg_sel == SEL_ACFG);

  // array commands not aimed at a special register go to the ports
  assign port_acc = ra_acc & ~sel_bist & ~sel_acfg;
  assign port_rd  = port_acc & ~cmd_we;

  // write port, byte selects only gate the whole write
  assign w0_enb = port_acc & cmd_we & (|cmd_sel);
  assign w0_adr = cmd_adr.arr.row;
  assign w0_dat = cmd_dat;

  // r0 serves every form except r1 alone
  assign r0_enb = port_rd & (cmd_adr.arr.rd_type != RD_R1);
  assign r0_adr = cmd_adr.arr.row;

  // r1 serves every form except r0 alone
  // paired forms take the second row field
  assign r1_enb = port_rd & (cmd_adr.arr.rd_type != RD_R0);
  assign r1_adr = (cmd_adr.arr.rd_type == RD_R1) ? cmd_adr.arr.row : cmd_adr.arr.r1_row;

  // bist control is a one cycle pulse carrying the data
  assign bist_ctl  = (ra_acc & sel_bist & cmd_we) ? cmd_dat : '0;
  assign acfg_wr   = ra_acc & sel_acfg & cmd_we;
  assign acfg_wdat = cmd_dat;

  // control writes to unknown selectors fall away here
  assign cfg0_we   = ctl_acc & sel_cfg0 & cmd_we;
  assign cfg0_mode = cmd_adr.ctl.wr_type;

  // every accepted read, of either kind, runs through the sequencer
  assign rd_start = (ctl_acc | ra_acc) & ~cmd_we;

  // read source, only looked at together with rd_start
  always_comb begin
    rd_src = SRC_NONE;
    if (ctl_cmd_val) begin
      if (sel_cfg0) begin
        rd_src = SRC_CFG0;
      end
    end else if (sel_bist) begin
      rd_src = SRC_BIST;
    end else if (sel_acfg) begin
      rd_src = SRC_ACFG;
    end else begin
      case (cmd_adr.arr.rd_type)
        RD_R0:      rd_src = SRC_R0;
        RD_R1:      rd_src = SRC_R1;
        RD_PAIR_LO: rd_src = SRC_PAIR_LO;
        default:    rd_src = SRC_PAIR_HI;
      endcase
    end
  end

endmodule

// File: logic/ctl_pkg.sv
// shared types and constants for the command front end, imported by every rtl module
package ctl_pkg;

  // fixed widths, the address union below is laid out around them
  localparam int DATA_W = 32;
  localparam int ROW_W  = 5;
  localparam int WAIT_W = 3;
  localparam int USER_W = 2;

  // register selectors carried in the top byte of the address
  localparam logic [7:0] SEL_CFG0 = 8'd1;
  localparam logic [7:0] SEL_BIST = 8'd2;
  localparam logic [7:0] SEL_ACFG = 8'd3;

  // cfg0 layout
  // run mode off, error off, user bits zero, two wait cycles
  localparam logic [DATA_W-1:0] CFG0_INIT = 32'h0000_0002;
  localparam int CFG0_RUN_BIT  = 31;
  localparam int CFG0_ERR_BIT  = 30;
  localparam int CFG0_USER_LSB = 28;

  // write modes for control writes
  typedef enum logic [1:0] {
    WR_REPLACE = 2'b00,
    WR_SET     = 2'b01,
    WR_CLEAR   = 2'b10,
    WR_TOGGLE  = 2'b11
  } wr_mode_e;

  // array read forms
  typedef enum logic [1:0] {
    RD_R0      = 2'b00,
    RD_R1      = 2'b01,
    RD_PAIR_LO = 2'b10,
    RD_PAIR_HI = 2'b11
  } rd_form_e;

  // where the read sequencer takes rd_dat from
  // SRC_NONE answers with all ones
  typedef enum logic [2:0] {
    SRC_R0      = 3'd0,
    SRC_R1      = 3'd1,
    SRC_PAIR_LO = 3'd2,
    SRC_PAIR_HI = 3'd3,
    SRC_CFG0    = 3'd4,
    SRC_BIST    = 3'd5,
    SRC_ACFG    = 3'd6,
    SRC_NONE    = 3'd7
  } rd_src_e;

  // control view of the command address
  typedef struct packed {
    logic [7:0]  reg_sel;
    logic [19:0] spare;
    wr_mode_e    wr_type;
    logic [1:0]  byte_off;
  } ctl_view_t;

  // array view, row serves r0, w0 and single r1 reads
  typedef struct packed {
    logic [14:0]      spare_hi;
    rd_form_e         rd_type;
    logic [ROW_W-1:0] r1_row;
    logic [2:0]       spare_mid;
    logic [ROW_W-1:0] row;
    logic [1:0]       byte_off;
  } arr_view_t;

  // one 32 bit address, decoded as either view
  typedef union packed {
    ctl_view_t ctl;
    arr_view_t arr;
  } cmd_adr_t;

endpackage

// File: logic/ctl_top.sv
// top of the command front end: decode, cfg0 register and read sequencer wired together
module ctl_top
  import ctl_pkg::*;
(
  input  logic              clk,
  input  logic              rst,

  // requester side
  input  logic              ctl_cmd_val,
  input  logic              ra_cmd_val,
  input  cmd_adr_t          cmd_adr,
  input  logic              cmd_we,
  input  logic [3:0]        cmd_sel,
  input  logic [DATA_W-1:0] cmd_dat,
  output logic              cmd_ready,
  output logic              rd_ack,
  output logic [DATA_W-1:0] rd_dat,

  // register array ports
  output logic              r0_enb,
  output logic [ROW_W-1:0]  r0_adr,
  input  logic [DATA_W-1:0] r0_dat,
  output logic              r1_enb,
  output logic [ROW_W-1:0]  r1_adr,
  input  logic [DATA_W-1:0] r1_dat,
  output logic              w0_enb,
  output logic [ROW_W-1:0]  w0_adr,
  output logic [DATA_W-1:0] w0_dat,

  // array side special registers
  output logic [DATA_W-1:0] bist_ctl,
  input  logic [DATA_W-1:0] bist_status,
  output logic              acfg_wr,
  output logic [DATA_W-1:0] acfg_wdat,
  input  logic [DATA_W-1:0] acfg_rdat,

  // status pins from cfg0
  output logic              run_mode,
  output logic              error,
  output logic [USER_W-1:0] user_out
);

  logic              idle;
  logic              cfg0_we;
  wr_mode_e          cfg0_mode;
  logic [DATA_W-1:0] cfg0;
  logic [WAIT_W-1:0] wait_cnt;
  logic              rd_start;
  rd_src_e           rd_src;

  // command acceptance and strobe generation
  cmd_decode cmd_decode_i (
    .ctl_cmd_val (ctl_cmd_val),
    .ra_cmd_val  (ra_cmd_val),
    .cmd_adr     (cmd_adr),
    .cmd_we      (cmd_we),
    .cmd_sel     (cmd_sel),
    .cmd_dat     (cmd_dat),
    .idle        (idle),
    .cmd_ready   (cmd_ready),
    .r0_enb      (r0_enb),
    .r0_adr      (r0_adr),
    .r1_enb      (r1_enb),
    .r1_adr      (r1_adr),
    .w0_enb      (w0_enb),
    .w0_adr      (w0_adr),
    .w0_dat      (w0_dat),
    .bist_ctl    (bist_ctl),
    .acfg_wr     (acfg_wr),
    .acfg_wdat   (acfg_wdat),
    .cfg0_we     (cfg0_we),
    .cfg0_mode   (cfg0_mode),
    .rd_start    (rd_start),
    .rd_src      (rd_src)
  );

  // control register, data comes straight from the command
  cfg0_reg cfg0_reg_i (
    .clk      (clk),
    .rst      (rst),
    .we       (cfg0_we),
    .mode     (cfg0_mode),
    .wdat     (cmd_dat),
    .cfg0     (cfg0),
    .wait_cnt (wait_cnt),
    .run_mode (run_mode),
    .error    (error),
    .user_out (user_out)
  );

  // read timing and return data
  read_sequencer read_sequencer_i (
    .clk         (clk),
    .rst         (rst),
    .rd_start    (rd_start),
    .rd_src      (rd_src),
    .wait_cnt    (wait_cnt),
    .cfg0        (cfg0),
    .r0_dat      (r0_dat),
    .r1_dat      (r1_dat),
    .bist_status (bist_status),
    .acfg_rdat   (acfg_rdat),
    .idle        (idle),
    .rd_ack      (rd_ack),
    .rd_dat      (rd_dat)
  );

endmodule

// File: logic/read_sequencer.sv
// read sequencer: waits the cfg0 cycle count after a read start, then acks and returns the data
module read_sequencer
  import ctl_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              rd_start,
  input  rd_src_e           rd_src,
  input  logic [WAIT_W-1:0] wait_cnt,
  input  logic [DATA_W-1:0] cfg0,
  input  logic [DATA_W-1:0] r0_dat,
  input  logic [DATA_W-1:0] r1_dat,
  input  logic [DATA_W-1:0] bist_status,
  input  logic [DATA_W-1:0] acfg_rdat,
  output logic              idle,
  output logic              rd_ack,
  output logic [DATA_W-1:0] rd_dat
);

  localparam int HALF_W = DATA_W / 2;

  // two states, waiting set means a read is in flight
  logic              waiting;
  logic [WAIT_W-1:0] cnt;
  rd_src_e           src_q;

  // cnt is loaded with the wait value on the start edge
  // and ticks down once per cycle until it hits zero
  always_ff @(posedge clk) begin
    if (rst) begin
      waiting <= 1'b0;
      cnt     <= '0;
      src_q   <= SRC_NONE;
    end else begin
      if (rd_start) begin
        waiting <= 1'b1;
        cnt     <= wait_cnt;
        src_q   <= rd_src;
      end else if (waiting) begin
        if (cnt == '0) begin
          // ack cycle, back to idle next
          waiting <= 1'b0;
        end else begin
          cnt <= cnt - 1'b1;
        end
      end
    end
  end

  assign idle = ~waiting;

  // one cycle ack, wait value plus one cycles after the start
  assign rd_ack = waiting & (cnt == '0);

  // return data from the held source
  // array data stays valid until the next read so a plain mux is enough
  always_comb begin
    case (src_q)
      SRC_R0: begin
        rd_dat = r0_dat;
      end
      SRC_R1: begin
        rd_dat = r1_dat;
      end
      SRC_PAIR_LO: begin
        // r1 in the upper half, r0 in the lower
        rd_dat = {r1_dat[HALF_W-1:0], r0_dat[HALF_W-1:0]};
      end
      SRC_PAIR_HI: begin
        rd_dat = {r1_dat[DATA_W-1:HALF_W], r0_dat[DATA_W-1:HALF_W]};
      end
      SRC_CFG0: begin
        rd_dat = cfg0;
      end
      SRC_BIST: begin
        rd_dat = bist_status;
      end
      SRC_ACFG: begin
        rd_dat = acfg_rdat;
      end
      default: begin
        // unmapped selector
        rd_dat = '1;
      end
    endcase
  end

endmodule

// File: run.sh
#!/bin/sh
# builds the ctl_top testbench with verilator, runs it and scans the log for the result
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f ctl_top.f --top-module ctl_top_tb -o ctl_top_sim
./obj_dir/ctl_top_sim | tee sim.log
if grep -q "STATUS: FAIL" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
if ! grep -q "STATUS: PASS" sim.log; then
  echo "simulation ended without a result line"
  exit 1
fi
echo "simulation passed"

// File: tests/ctl_checker.sv
// testbench checker that shadows the DUT registers and compares every response
module ctl_checker
  import ctl_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic [127:0]      test_name,
  input  logic              ctl_cmd_val,
  input  logic              ra_cmd_val,
  input  cmd_adr_t          cmd_adr,
  input  logic              cmd_we,
  input  logic [3:0]        cmd_sel,
  input  logic [DATA_W-1:0] cmd_dat,
  input  logic              cmd_ready,
  input  logic              rd_ack,
  input  logic [DATA_W-1:0] rd_dat,
  input  logic              r0_enb,
  input  logic              r1_enb,
  input  logic              w0_enb,
  input  logic              acfg_wr,
  input  logic [DATA_W-1:0] bist_ctl,
  input  logic              run_mode,
  input  logic              error,
  input  logic [USER_W-1:0] user_out,
  output int                checks,
  output int                value_errs,
  output int                proto_errs
);

  // shadow state updated on accepted writes
  logic [DATA_W-1:0] cfg0_s;
  logic [DATA_W-1:0] acfg_s;
  logic [DATA_W-1:0] bist_s;
  logic [DATA_W-1:0] mem_s [32];

  // the one read in flight
  logic              pending;
  int                age;
  int                lat_exp;
  logic [DATA_W-1:0] dat_exp;

  // expected read data for an accepted read command
  function automatic logic [DATA_W-1:0] expected_rd(input logic is_ctl, input cmd_adr_t adr);
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    a = mem_s[adr.arr.row];
    b = mem_s[adr.arr.r1_row];
    if (is_ctl) begin
      // only cfg0 is mapped on the control side
      return (adr.ctl.reg_sel == SEL_CFG0) ? cfg0_s : '1;
    end
    if (adr.ctl.reg_sel == SEL_BIST) begin
      return ~bist_s;
    end
    if (adr.ctl.reg_sel == SEL_ACFG) begin
      return acfg_s;
    end
    case (adr.arr.rd_type)
      RD_R0:      return a;
      RD_R1:      return a;
      RD_PAIR_LO: return {b[15:0], a[15:0]};
      default:    return {b[31:16], a[31:16]};
    endcase
  endfunction

  task automatic compare(input string what, input logic [DATA_W-1:0] exp,
                         input logic [DATA_W-1:0] act);
    checks++;
    if (act !== exp) begin
      value_errs++;
      $display("CHECK FAILED %0s: %0s expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic protocol_error(input string what);
    proto_errs++;
    $display("protocol error in %0s: %0s", test_name, what);
  endtask

  // sampled on the rising edge while inputs move on the falling edge
  always @(posedge clk) begin : sample
    logic              acc;
    logic              spec;
    logic              port_rd;
    logic [3:0]        strb_exp;
    logic [DATA_W-1:0] bist_exp;
    if (rst) begin
      cfg0_s     = CFG0_INIT;
      acfg_s     = '0;
      bist_s     = '0;
      pending    = 1'b0;
      age        = 0;
      lat_exp    = 0;
      dat_exp    = '0;
      checks     = 0;
      value_errs = 0;
      proto_errs = 0;
    end else begin
      acc  = (ctl_cmd_val | ra_cmd_val) & cmd_ready;
      spec = (cmd_adr.ctl.reg_sel == SEL_BIST) | (cmd_adr.ctl.reg_sel == SEL_ACFG);
      port_rd = acc & ra_cmd_val & ~spec & ~cmd_we;

      // strobe bits in the order w0 r0 r1 acfg
      strb_exp[3] = acc & ra_cmd_val & ~spec & cmd_we & (|cmd_sel);
      strb_exp[2] = port_rd & (cmd_adr.arr.rd_type inside {RD_R0, RD_PAIR_LO, RD_PAIR_HI});
      strb_exp[1] = port_rd & (cmd_adr.arr.rd_type inside {RD_R1, RD_PAIR_LO, RD_PAIR_HI});
      strb_exp[0] = acc & ra_cmd_val & (cmd_adr.ctl.reg_sel == SEL_ACFG) & cmd_we;
      compare("strobes w0 r0 r1 acfg", 32'(strb_exp), 32'({w0_enb, r0_enb, r1_enb, acfg_wr}));

      // bist_ctl carries data only in its write cycle
      bist_exp = (acc & ra_cmd_val & (cmd_adr.ctl.reg_sel == SEL_BIST) & cmd_we) ? cmd_dat : '0;
      compare("bist_ctl", bist_exp, bist_ctl);

      // status pins follow the shadow cfg0 one cycle after a write
      compare("status pins", {28'd0, cfg0_s[31:28]}, {28'd0, run_mode, error, user_out});

      // ready is low exactly while a read is outstanding
      if (pending === cmd_ready) begin
        if (pending) begin
          protocol_error("cmd_ready high while a read is outstanding");
        end else begin
          protocol_error("cmd_ready low with no read outstanding");
        end
      end

      if (pending) begin
        age++;
        if (rd_ack) begin
          compare("rd_ack latency", 32'(lat_exp), 32'(age));
          compare("rd_dat", dat_exp, rd_dat);
          pending = 1'b0;
        end else if (age > lat_exp) begin
          protocol_error("no rd_ack within the expected number of cycles");
          pending = 1'b0;
        end
      end else if (rd_ack) begin
        protocol_error("rd_ack with no read outstanding");
      end

      if (acc) begin
        if (!cmd_we) begin
          pending = 1'b1;
          age     = 0;
          lat_exp = int'(cfg0_s[WAIT_W-1:0]) + 1;
          dat_exp = expected_rd(ctl_cmd_val, cmd_adr);
        end else if (ctl_cmd_val) begin
          if (cmd_adr.ctl.reg_sel == SEL_CFG0) begin
            case (cmd_adr.ctl.wr_type)
              WR_REPLACE: cfg0_s = cmd_dat;
              WR_SET:     cfg0_s = cfg0_s | cmd_dat;
              WR_CLEAR:   cfg0_s = cfg0_s & ~cmd_dat;
              default:    cfg0_s = cfg0_s ^ cmd_dat;
            endcase
          end
        end else if (cmd_adr.ctl.reg_sel == SEL_BIST) begin
          // the array keeps the last nonzero control word
          if (cmd_dat != '0) begin
            bist_s = cmd_dat;
          end
        end else if (cmd_adr.ctl.reg_sel == SEL_ACFG) begin
          acfg_s = cmd_dat;
        end else if (|cmd_sel) begin
          mem_s[cmd_adr.arr.row] = cmd_dat;
        end
      end
    end
  end

endmodule

// File: tests/ctl_top_tb.sv
// testbench for the command front end with clock, reset, array model and command stimulus
module ctl_top_tb
  import ctl_pkg::*;
();

  logic              clk;
  logic              rst;
  logic              ctl_cmd_val;
  logic              ra_cmd_val;
  cmd_adr_t          cmd_adr;
  logic              cmd_we;
  logic [3:0]        cmd_sel;
  logic [DATA_W-1:0] cmd_dat;
  logic              cmd_ready;
  logic              rd_ack;
  logic [DATA_W-1:0] rd_dat;
  logic              r0_enb;
  logic [ROW_W-1:0]  r0_adr;
  logic              r1_enb;
  logic [ROW_W-1:0]  r1_adr;
  logic              w0_enb;
  logic [ROW_W-1:0]  w0_adr;
  logic [DATA_W-1:0] w0_dat;
  logic [DATA_W-1:0] bist_ctl;
  logic [DATA_W-1:0] bist_status;
  logic              acfg_wr;
  logic [DATA_W-1:0] acfg_wdat;
  logic              run_mode;
  logic              error;
  logic [USER_W-1:0] user_out;

  logic [127:0]      test_name;
  logic [31:0]       lfsr;
  int                timeouts;
  int                checks;
  int                value_errs;
  int                proto_errs;

  // behavioral register array that holds read data until the next read
  logic [DATA_W-1:0] mem [32];
  logic [DATA_W-1:0] r0_q;
  logic [DATA_W-1:0] r1_q;
  logic [DATA_W-1:0] acfg_q;
  logic [DATA_W-1:0] bist_q;

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    if (rst) begin
      acfg_q <= '0;
      bist_q <= '0;
    end else begin
      if (w0_enb) begin
        mem[w0_adr] <= w0_dat;
      end
      if (r0_enb) begin
        r0_q <= mem[r0_adr];
      end
      if (r1_enb) begin
        r1_q <= mem[r1_adr];
      end
      if (acfg_wr) begin
        acfg_q <= acfg_wdat;
      end
      // bist latches any nonzero control word
      if (bist_ctl != '0) begin
        bist_q <= bist_ctl;
      end
    end
  end

  assign bist_status = ~bist_q;

  ctl_top ctl_top_i (
    .clk         (clk),
    .rst         (rst),
    .ctl_cmd_val (ctl_cmd_val),
    .ra_cmd_val  (ra_cmd_val),
    .cmd_adr     (cmd_adr),
    .cmd_we      (cmd_we),
    .cmd_sel     (cmd_sel),
    .cmd_dat     (cmd_dat),
    .cmd_ready   (cmd_ready),
    .rd_ack      (rd_ack),
    .rd_dat      (rd_dat),
    .r0_enb      (r0_enb),
    .r0_adr      (r0_adr),
    .r0_dat      (r0_q),
    .r1_enb      (r1_enb),
    .r1_adr      (r1_adr),
    .r1_dat      (r1_q),
    .w0_enb      (w0_enb),
    .w0_adr      (w0_adr),
    .w0_dat      (w0_dat),
    .bist_ctl    (bist_ctl),
    .bist_status (bist_status),
    .acfg_wr     (acfg_wr),
    .acfg_wdat   (acfg_wdat),
    .acfg_rdat   (acfg_q),
    .run_mode    (run_mode),
    .error       (error),
    .user_out    (user_out)
  );

  ctl_checker ctl_checker_i (
    .clk         (clk),
    .rst         (rst),
    .test_name   (test_name),
    .ctl_cmd_val (ctl_cmd_val),
    .ra_cmd_val  (ra_cmd_val),
    .cmd_adr     (cmd_adr),
    .cmd_we      (cmd_we),
    .cmd_sel     (cmd_sel),
    .cmd_dat     (cmd_dat),
    .cmd_ready   (cmd_ready),
    .rd_ack      (rd_ack),
    .rd_dat      (rd_dat),
    .r0_enb      (r0_enb),
    .r1_enb      (r1_enb),
    .w0_enb      (w0_enb),
    .acfg_wr     (acfg_wr),
    .bist_ctl    (bist_ctl),
    .run_mode    (run_mode),
    .error       (error),
    .user_out    (user_out),
    .checks      (checks),
    .value_errs  (value_errs),
    .proto_errs  (proto_errs)
  );

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic cmd_adr_t ctl_adr(input logic [7:0] sel, input wr_mode_e mode);
    cmd_adr_t a;
    a = '0;
    a.ctl.reg_sel = sel;
    a.ctl.wr_type = mode;
    return a;
  endfunction

  function automatic cmd_adr_t arr_adr(input rd_form_e form, input logic [ROW_W-1:0] row,
                                       input logic [ROW_W-1:0] r1_row);
    cmd_adr_t a;
    a = '0;
    a.arr.rd_type = form;
    a.arr.row     = row;
    a.arr.r1_row  = r1_row;
    return a;
  endfunction

  task automatic report_and_finish();
    $display("summary: %0d checks, %0d value errors, %0d protocol errors, %0d timeouts",
             checks, value_errs, proto_errs, timeouts);
    if (checks > 0 && value_errs == 0 && proto_errs == 0 && timeouts == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  endtask

  // steps falling edges until one sees cmd_ready high
  // after any timeout the remaining waits fall through at once
  task automatic wait_ready();
    int n;
    n = 0;
    while (!cmd_ready && timeouts == 0) begin
      if (n == 40) begin
        timeouts++;
        $display("timeout in %0s: cmd_ready stayed low for 40 cycles", test_name);
      end else begin
        n++;
        @(negedge clk);
      end
    end
  endtask

  task automatic wait_ack();
    int n;
    n = 0;
    while (!rd_ack && timeouts == 0) begin
      if (n == 16) begin
        timeouts++;
        $display("timeout in %0s: no rd_ack within 16 cycles", test_name);
      end else begin
        n++;
        @(negedge clk);
      end
    end
  endtask

  // offers one command when ready and drops the valid one cycle later
  task automatic issue(input logic is_ctl, input cmd_adr_t adr, input logic we,
                       input logic [3:0] sel, input logic [DATA_W-1:0] dat);
    wait_ready();
    ctl_cmd_val = is_ctl;
    ra_cmd_val  = ~is_ctl;
    cmd_adr     = adr;
    cmd_we      = we;
    cmd_sel     = sel;
    cmd_dat     = dat;
    @(negedge clk);
    ctl_cmd_val = 1'b0;
    ra_cmd_val  = 1'b0;
  endtask

  task automatic send(input logic is_ctl, input cmd_adr_t adr, input logic we,
                      input logic [3:0] sel, input logic [DATA_W-1:0] dat);
    issue(is_ctl, adr, we, sel, dat);
    if (!we) begin
      wait_ack();
    end
  endtask

  initial begin : stimulus
    logic [ROW_W-1:0]  row;
    logic [ROW_W-1:0]  r1;
    logic [DATA_W-1:0] d;
    int                w;
    lfsr        = 32'h0883_c45a;
    timeouts    = 0;
    rst         = 1'b1;
    ctl_cmd_val = 1'b0;
    ra_cmd_val  = 1'b0;
    cmd_adr     = '0;
    cmd_we      = 1'b0;
    cmd_sel     = 4'h0;
    cmd_dat     = '0;
    test_name   = "reset";
    repeat (3) @(negedge clk);
    rst = 1'b0;

    // every write mode followed by a readback
    test_name = "cfg0_modes";
    for (int m = 0; m < 4; m++) begin
      for (int k = 0; k < 3; k++) begin
        send(1'b1, ctl_adr(SEL_CFG0, wr_mode_e'(2'(m))), 1'b1, 4'hf, rand_bits(32));
        send(1'b1, ctl_adr(SEL_CFG0, WR_REPLACE), 1'b0, 4'hf, '0);
      end
    end

    // fill the whole array and read single words on both ports
    test_name = "array_rw";
    for (int i = 0; i < 32; i++) begin
      send(1'b0, arr_adr(RD_R0, 5'(i), 5'd0), 1'b1, 4'(rand_bits(4)) | 4'h1, rand_bits(32));
    end
    for (int i = 0; i < 8; i++) begin
      row = 5'(rand_bits(5));
      send(1'b0, arr_adr(RD_R0, row, 5'd0), 1'b0, 4'hf, '0);
      send(1'b0, arr_adr(RD_R1, row, 5'(rand_bits(5))), 1'b0, 4'hf, '0);
    end
    // no byte selects means no write
    row = 5'(rand_bits(5));
    send(1'b0, arr_adr(RD_R0, row, 5'd0), 1'b1, 4'h0, rand_bits(32));
    send(1'b0, arr_adr(RD_R0, row, 5'd0), 1'b0, 4'hf, '0);

    // nonzero xor keeps the two rows apart
    test_name = "pair_reads";
    for (int i = 0; i < 6; i++) begin
      row = 5'(rand_bits(5));
      r1  = row ^ (5'(rand_bits(4)) + 5'd1);
      send(1'b0, arr_adr((i % 2 == 0) ? RD_PAIR_LO : RD_PAIR_HI, row, r1), 1'b0, 4'hf, '0);
    end

    test_name = "special_regs";
    d = rand_bits(32) | 32'h1;
    send(1'b0, ctl_adr(SEL_BIST, WR_REPLACE), 1'b1, 4'hf, d);
    send(1'b0, ctl_adr(SEL_BIST, WR_REPLACE), 1'b0, 4'hf, '0);
    send(1'b0, ctl_adr(SEL_ACFG, WR_REPLACE), 1'b1, 4'hf, rand_bits(32));
    send(1'b0, ctl_adr(SEL_ACFG, WR_REPLACE), 1'b0, 4'hf, '0);
    // an unused control selector reads as all ones and drops writes
    send(1'b1, ctl_adr(8'h40, WR_REPLACE), 1'b0, 4'hf, '0);
    send(1'b1, ctl_adr(8'h40, WR_SET), 1'b1, 4'hf, '1);
    send(1'b1, ctl_adr(SEL_CFG0, WR_REPLACE), 1'b0, 4'hf, '0);

    test_name = "latency";
    for (int k = 0; k < 3; k++) begin
      w = (k == 0) ? 0 : (k == 1) ? 1 : 7;
      d = (rand_bits(32) & ~32'h7) | 32'(w);
      send(1'b1, ctl_adr(SEL_CFG0, WR_REPLACE), 1'b1, 4'hf, d);
      send(1'b0, arr_adr(RD_R0, 5'(rand_bits(5)), 5'd0), 1'b0, 4'hf, '0);
      send(1'b1, ctl_adr(SEL_CFG0, WR_REPLACE), 1'b0, 4'hf, '0);
    end
    // with a wait of 7 the read holds cmd_ready low while two writes are offered
    issue(1'b0, arr_adr(RD_R1, 5'd9, 5'd0), 1'b0, 4'hf, '0);
    ctl_cmd_val = 1'b1;
    cmd_adr     = ctl_adr(SEL_CFG0, WR_REPLACE);
    cmd_we      = 1'b1;
    cmd_dat     = '0;
    @(negedge clk);
    ctl_cmd_val = 1'b0;
    ra_cmd_val  = 1'b1;
    cmd_adr     = arr_adr(RD_R0, 5'd9, 5'd0);
    cmd_dat     = 32'hdead_beef;
    @(negedge clk);
    ra_cmd_val  = 1'b0;
    wait_ack();
    send(1'b1, ctl_adr(SEL_CFG0, WR_REPLACE), 1'b0, 4'hf, '0);
    send(1'b0, arr_adr(RD_R0, 5'd9, 5'd0), 1'b0, 4'hf, '0);

    test_name = "done";
    repeat (3) @(negedge clk);
    report_and_finish();
  end

endmodule
